//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = mem_stage_tb
FILELIST = mem_stage.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
PASS_MSG = Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/mem_stage_tb.sv
module mem_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RAM_DEPTH  = 256;
    localparam int WORD_AW    = $clog2(RAM_DEPTH);
    localparam int BYTE_AW    = WORD_AW + 3;
    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 4;
    localparam int N_DIRECTED = 80;                    // Upper bound on directed cycles
    localparam int N_RAND     = 2000;
    localparam int MAX_GAP    = 2;
    localparam int MAX_CYCLES = RST_CYCLES + RAM_DEPTH + N_DIRECTED
                                + N_RAND * (MAX_GAP + 1) + 50;

    localparam logic [3:0] ST_SD = 4'b1000;
    localparam logic [5:0] LD_LD = 6'b100000;

    typedef struct packed {
        logic [63:0] pc;
        logic [31:0] inst;
        logic        we;
        logic [4:0]  waddr;
        logic [63:0] data;
        logic [31:0] due;                              // Cycle that must show it
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        valid_i;
    logic [63:0] pc_i;
    logic [31:0] inst_i;
    logic [63:0] result_i;
    logic [63:0] store_data_i;
    logic [3:0]  store_width_i;
    logic [5:0]  load_width_i;
    logic        reg_we_i;
    logic [4:0]  reg_waddr_i;
    logic        wb_valid_o;
    logic [63:0] wb_pc_o;
    logic [31:0] wb_inst_o;
    logic        wb_we_o;
    logic [4:0]  wb_waddr_o;
    logic [63:0] wb_data_o;

    integer      seed;
    logic [31:0] cyc;
    logic [63:0] pc_next;
    logic [7:0]  shadow [RAM_DEPTH*8];                 // Byte image of the data RAM
    exp_t        exp_q [$];

    mem_stage_top #(.RAM_DEPTH(RAM_DEPTH)) u_mem_stage_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid_i),
        .pc_i          (pc_i),
        .inst_i        (inst_i),
        .result_i      (result_i),
        .store_data_i  (store_data_i),
        .store_width_i (store_width_i),
        .load_width_i  (load_width_i),
        .reg_we_i      (reg_we_i),
        .reg_waddr_i   (reg_waddr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_pc_o       (wb_pc_o),
        .wb_inst_o     (wb_inst_o),
        .wb_we_o       (wb_we_o),
        .wb_waddr_o    (wb_waddr_o),
        .wb_data_o     (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 32'd1;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [63:0] addr_of(input int word, input int off);
        return 64'(word * 8 + off);
    endfunction

    function automatic int load_bytes(input int l);
        return (l == 5) ? 8 : (1 << (l / 2));
    endfunction

    // Initial word contents scrambled from the full word index
    function automatic logic [63:0] fill_word(input int w);
        logic [31:0] a;
        a = 32'(w);
        return {a * 32'h9e37_79b9, ~a ^ 32'h5a5a_0f0f};
    endfunction

    // Expected writeback for one instruction and the shadow update of a store
    function automatic exp_t model_instr(input logic [63:0] pc, input logic [31:0] inst,
                                         input logic [63:0] addr, input logic [63:0] sdata,
                                         input logic [3:0] sw, input logic [5:0] lw,
                                         input logic we, input logic [4:0] waddr);
        exp_t               e;
        logic [BYTE_AW-1:0] base;
        int                 n;
        bit                 sext;
        logic [63:0]        val;
        base    = addr[BYTE_AW-1:0];
        e.pc    = pc;
        e.inst  = inst;
        e.we    = we && (waddr != 5'd0);
        e.waddr = waddr;
        e.data  = addr;
        e.due   = '0;
        case (sw)
            4'b0001: n = 1;
            4'b0010: n = 2;
            4'b0100: n = 4;
            4'b1000: n = 8;
            default: n = 0;
        endcase
        for (int i = 0; i < n; i++) begin
            shadow[base + BYTE_AW'(i)] = 8'(sdata >> (8 * i));
        end
        sext = lw[0] | lw[2] | lw[4];                  // lb, lh and lw extend the sign
        case (lw)
            6'b000001: n = 1;
            6'b000010: n = 1;
            6'b000100: n = 2;
            6'b001000: n = 2;
            6'b010000: n = 4;
            6'b100000: n = 8;
            default:   n = 0;
        endcase
        if (n != 0) begin
            val = '0;
            for (int i = 0; i < n; i++) begin
                val = val | (64'(shadow[base + BYTE_AW'(i)]) << (8 * i));
            end
            if (sext && ((val >> (8 * n - 1)) & 64'd1) != 64'd0) begin
                val = val | (~64'd0 << (8 * n));
            end
            e.data = val;
        end
        return e;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] want);
        if (got !== want) begin
            $display("** Error %s: got %h, expected %h", name, got, want);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic issue(input logic [63:0] addr, input logic [63:0] sdata,
                         input logic [3:0] sw, input logic [5:0] lw,
                         input logic we, input logic [4:0] waddr);
        exp_t        e;
        logic [31:0] inst;
        inst  = $random(seed);
        e     = model_instr(pc_next, inst, addr, sdata, sw, lw, we, waddr);
        e.due = cyc + 32'd2;
        exp_q.push_back(e);
        valid_i       = 1'b1;
        pc_i          = pc_next;
        inst_i        = inst;
        result_i      = addr;
        store_data_i  = sdata;
        store_width_i = sw;
        load_width_i  = lw;
        reg_we_i      = we;
        reg_waddr_i   = waddr;
        pc_next       = pc_next + 64'd4;
        step();
        valid_i = 1'b0;
    endtask

    always @(negedge clk) begin
        exp_t e;
        if (wb_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                report_failure("wb_valid_o went high with no instruction outstanding");
            end else begin
                e = exp_q.pop_front();
                if (e.due != cyc) begin
                    report_failure("wb_valid_o came in the wrong cycle");
                end else begin
                    check_val("wb_pc_o", wb_pc_o, e.pc);
                    check_val("wb_inst_o", 64'(wb_inst_o), 64'(e.inst));
                    check_val("wb_we_o", 64'(wb_we_o), 64'(e.we));
                    check_val("wb_waddr_o", 64'(wb_waddr_o), 64'(e.waddr));
                    check_val("wb_data_o", wb_data_o, e.data);
                end
            end
        end else if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            report_failure("wb_valid_o stayed low when an instruction was due");
        end
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("Timeout: run went past %0d cycles", MAX_CYCLES);
        $display("Done: errors found");
        $fatal(1);
    end

    initial begin
        int kind;
        int word;
        int s;
        int l;
        seed          = 32'hf402;
        cyc           = '0;
        pc_next       = 64'h8000_0000;
        rst_n         = 1'b1;                          // Reset active while high
        valid_i       = 1'b1;                          // Reset has to drop this write
        pc_i          = '0;
        inst_i        = '0;
        result_i      = '0;
        store_data_i  = '0;
        store_width_i = '0;
        load_width_i  = '0;
        reg_we_i      = 1'b1;
        reg_waddr_i   = 5'd1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n       = 1'b0;
        valid_i     = 1'b0;
        reg_we_i    = 1'b0;
        reg_waddr_i = '0;

        for (int i = 0; i < 4; i++) begin
            step();
            check_val("wb_valid_o", 64'(wb_valid_o), 64'd0);
            check_val("wb_we_o", 64'(wb_we_o), 64'd0);
        end
        issue(64'h1234_5678_9abc_def0, rand64(), '0, '0, 1'b1, 5'd7);

        for (int w = 0; w < RAM_DEPTH; w++) begin
            issue(addr_of(w, 0), fill_word(w), ST_SD, '0, 1'b0, 5'd0);
        end

        // Each store width at each offset followed by a read back of the whole word
        for (int sw = 0; sw < 4; sw++) begin
            for (int off = 0; off < 8; off += (1 << sw)) begin
                issue(addr_of(10 + sw, off), rand64(), 4'(1 << sw), '0, 1'b0, 5'd0);
                issue(addr_of(10 + sw, 0), '0, '0, LD_LD, 1'b1, 5'(1 + sw));
            end
        end

        issue(addr_of(20, 0), 64'h8070_ff01_7f80_00ff, ST_SD, '0, 1'b0, 5'd0);
        for (int ld = 0; ld < 6; ld++) begin
            for (int off = 0; off < 8; off += load_bytes(ld)) begin
                issue(addr_of(20, off), '0, '0, 6'(1 << ld), 1'b1, 5'(8 + ld));
            end
        end

        issue(rand64(), rand64(), '0, '0, 1'b1, 5'd0);
        issue(addr_of(20, 0), '0, '0, LD_LD, 1'b1, 5'd0);

        for (int n = 0; n < N_RAND; n++) begin
            kind = rand_below(3);
            word = rand_below(RAM_DEPTH);
            if (kind == 0) begin
                s = rand_below(4);
                issue(addr_of(word, rand_below(8 >> s) << s), rand64(), 4'(1 << s), '0,
                      1'b0, 5'd0);
            end else if (kind == 1) begin
                l = rand_below(6);
                issue(addr_of(word, rand_below(8 / load_bytes(l)) * load_bytes(l)),
                      rand64(), '0, 6'(1 << l), 1'b1, 5'(rand_below(32)));
            end else begin
                issue(rand64(), rand64(), '0, '0, 1'(rand_below(2)), 5'(rand_below(32)));
            end
            if (rand_below(4) == 0) begin
                idle(rand_below(MAX_GAP + 1));
            end
        end

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle(4);
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- mem_stage.f
src/mem_stage_pkg.sv
src/ram_if.sv
src/pipe_reg.sv
src/mem_access.sv
src/data_ram.sv
src/mem_stage_top.sv
bench/mem_stage_tb.sv

//--- src/data_ram.sv
module data_ram #(
    parameter int RAM_DEPTH = 256
) (
    input logic  clk,
    ram_if.slave ram
);

    logic [mem_stage_pkg::XLEN-1:0] mem [RAM_DEPTH];

    // Byte-lane write of one word per edge
    always_ff @(posedge clk) begin
        if (ram.we) begin
            for (int i = 0; i < mem_stage_pkg::BE_W; i++) begin
                if (ram.be[i]) begin
                    mem[ram.addr][i*8 +: 8] <= ram.wdata[i*8 +: 8];
                end
            end
        end
    end

    assign ram.rdata = mem[ram.addr];                   // Asynchronous read

    a_be_on_write: assert property (@(posedge clk) ram.we |-> ram.be != '0)
        else $error("data_ram: write with no byte enables at word %0d", ram.addr);

endmodule

//--- src/mem_access.sv
module mem_access #(
    parameter int RAM_DEPTH = 256
) (
    input  mem_stage_pkg::ex_mem_t ex_i,
    ram_if.master                  ram,
    output mem_stage_pkg::mem_wb_t wb_o
);

    localparam int AW = $clog2(RAM_DEPTH);

    logic                                 is_store;
    logic                                 is_load;
    logic [mem_stage_pkg::OFF_W-1:0]      byte_off;
    logic [mem_stage_pkg::BE_W-1:0]       be_base;     // Enables for offset zero
    logic [mem_stage_pkg::XLEN-1:0]       wdata_rep;
    logic [mem_stage_pkg::XLEN-1:0]       rd_shift;
    logic [mem_stage_pkg::XLEN-1:0]       load_val;
    logic [mem_stage_pkg::OFF_W-1:0]      align_mask;  // Offset bits that must be zero

    assign is_store = |ex_i.store_width;
    assign is_load  = |ex_i.load_width;
    assign byte_off = ex_i.result[mem_stage_pkg::OFF_W-1:0];

    always_comb begin
        be_base    = '0;
        wdata_rep  = ex_i.store_data;
        align_mask = '0;
        case (1'b1)
            ex_i.store_width[mem_stage_pkg::ST_B]: begin
                be_base   = 8'h01;
                wdata_rep = {8{ex_i.store_data[7:0]}};
            end
            ex_i.store_width[mem_stage_pkg::ST_H]: begin
                be_base    = 8'h03;
                wdata_rep  = {4{ex_i.store_data[15:0]}};
                align_mask = 3'b001;
            end
            ex_i.store_width[mem_stage_pkg::ST_W_BIT]: begin
                be_base    = 8'h0f;
                wdata_rep  = {2{ex_i.store_data[31:0]}};
                align_mask = 3'b011;
            end
            ex_i.store_width[mem_stage_pkg::ST_D]: begin
                be_base    = 8'hff;
                align_mask = 3'b111;
            end
            ex_i.load_width[mem_stage_pkg::LD_H],
            ex_i.load_width[mem_stage_pkg::LD_HU]:    align_mask = 3'b001;
            ex_i.load_width[mem_stage_pkg::LD_W_BIT]: align_mask = 3'b011;
            ex_i.load_width[mem_stage_pkg::LD_D]:     align_mask = 3'b111;
            default: ;
        endcase
    end

    // Store commits at the edge that ends this cycle
    assign ram.we    = ex_i.valid & is_store;
    assign ram.be    = be_base << byte_off;
    assign ram.addr  = ex_i.result[mem_stage_pkg::OFF_W +: AW];
    assign ram.wdata = wdata_rep;

    // Bring the addressed bytes down to lane zero
    assign rd_shift = ram.rdata >> {byte_off, 3'b000};

    always_comb begin
        case (1'b1)
            ex_i.load_width[mem_stage_pkg::LD_B]:
                load_val = {{56{rd_shift[7]}}, rd_shift[7:0]};
            ex_i.load_width[mem_stage_pkg::LD_BU]:
                load_val = {56'b0, rd_shift[7:0]};
            ex_i.load_width[mem_stage_pkg::LD_H]:
                load_val = {{48{rd_shift[15]}}, rd_shift[15:0]};
            ex_i.load_width[mem_stage_pkg::LD_HU]:
                load_val = {48'b0, rd_shift[15:0]};
            ex_i.load_width[mem_stage_pkg::LD_W_BIT]:
                load_val = {{32{rd_shift[31]}}, rd_shift[31:0]};
            default:
                load_val = rd_shift;                     // ld
        endcase
    end

    assign wb_o.valid    = ex_i.valid;
    assign wb_o.pc       = ex_i.pc;
    assign wb_o.inst     = ex_i.inst;
    assign wb_o.wb_we    = ex_i.valid & ex_i.reg_we & (ex_i.reg_waddr != '0);
    assign wb_o.wb_waddr = ex_i.reg_waddr;
    assign wb_o.wb_data  = is_load ? load_val : ex_i.result;

    // Decode from execute must hand over at most one access kind
    a_width_codes: assert property (@(posedge ram.clk)
        ex_i.valid |-> $onehot0(ex_i.store_width) && $onehot0(ex_i.load_width)
                       && !(is_store && is_load))
        else $error("mem_access: bad width codes st=%h ld=%h",
                    ex_i.store_width, ex_i.load_width);

    a_aligned: assert property (@(posedge ram.clk)
        ex_i.valid && (is_store || is_load) |-> (byte_off & align_mask) == '0)
        else $error("mem_access: misaligned address %h", ex_i.result);

endmodule

//--- src/mem_stage_pkg.sv
package mem_stage_pkg;

    localparam int XLEN   = 64;
    localparam int REG_AW = 5;
    localparam int INST_W = 32;
    localparam int BE_W   = XLEN / 8;                  // Byte lanes per data word
    localparam int OFF_W  = $clog2(BE_W);              // Byte offset bits inside a word

    // One-hot store width code that is all zero for a non-store
    localparam int ST_W     = 4;
    localparam int ST_B     = 0;                       // sb
    localparam int ST_H     = 1;                       // sh
    localparam int ST_W_BIT = 2;                       // sw
    localparam int ST_D     = 3;                       // sd

    // One-hot load width code that is all zero for a non-load
    localparam int LD_W     = 6;
    localparam int LD_B     = 0;                       // lb
    localparam int LD_BU    = 1;                       // lbu
    localparam int LD_H     = 2;                       // lh
    localparam int LD_HU    = 3;                       // lhu
    localparam int LD_W_BIT = 4;                       // lw
    localparam int LD_D     = 5;                       // ld

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [INST_W-1:0] inst;
        logic [XLEN-1:0]   result;                     // Address or ALU value
        logic [XLEN-1:0]   store_data;
        logic [ST_W-1:0]   store_width;
        logic [LD_W-1:0]   load_width;
        logic              reg_we;
        logic [REG_AW-1:0] reg_waddr;
    } ex_mem_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [INST_W-1:0] inst;
        logic              wb_we;                      // Already low for x0
        logic [REG_AW-1:0] wb_waddr;
        logic [XLEN-1:0]   wb_data;
    } mem_wb_t;

endpackage

//--- src/mem_stage_top.sv
module mem_stage_top #(
    parameter int RAM_DEPTH = 256
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   valid_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         pc_i,
    input  logic [mem_stage_pkg::INST_W-1:0]       inst_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         result_i,
    input  logic [mem_stage_pkg::XLEN-1:0]         store_data_i,
    input  logic [mem_stage_pkg::ST_W-1:0]         store_width_i,
    input  logic [mem_stage_pkg::LD_W-1:0]         load_width_i,
    input  logic                                   reg_we_i,
    input  logic [mem_stage_pkg::REG_AW-1:0]       reg_waddr_i,
    output logic                                   wb_valid_o,
    output logic [mem_stage_pkg::XLEN-1:0]         wb_pc_o,
    output logic [mem_stage_pkg::INST_W-1:0]       wb_inst_o,
    output logic                                   wb_we_o,
    output logic [mem_stage_pkg::REG_AW-1:0]       wb_waddr_o,
    output logic [mem_stage_pkg::XLEN-1:0]         wb_data_o
);

    localparam int AW = $clog2(RAM_DEPTH);

    mem_stage_pkg::ex_mem_t ex_d;
    mem_stage_pkg::ex_mem_t ex_q;
    mem_stage_pkg::mem_wb_t wb_d;
    mem_stage_pkg::mem_wb_t wb_q;

    assign ex_d = '{
        valid:       valid_i,
        pc:          pc_i,
        inst:        inst_i,
        result:      result_i,
        store_data:  store_data_i,
        store_width: store_width_i,
        load_width:  load_width_i,
        reg_we:      reg_we_i,
        reg_waddr:   reg_waddr_i
    };

    ram_if #(.AW(AW)) u_ram_if (.clk(clk));

    pipe_reg #(.payload_t(mem_stage_pkg::ex_mem_t)) u_ex_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .d_i   (ex_d),
        .q_o   (ex_q)
    );

    mem_access #(.RAM_DEPTH(RAM_DEPTH)) u_mem_access (
        .ex_i (ex_q),
        .ram  (u_ram_if.master),
        .wb_o (wb_d)
    );

    data_ram #(.RAM_DEPTH(RAM_DEPTH)) u_data_ram (
        .clk (clk),
        .ram (u_ram_if.slave)
    );

    pipe_reg #(.payload_t(mem_stage_pkg::mem_wb_t)) u_mem_wb (
        .clk   (clk),
        .rst_n (rst_n),
        .d_i   (wb_d),
        .q_o   (wb_q)
    );

    assign wb_valid_o = wb_q.valid;
    assign wb_pc_o    = wb_q.pc;
    assign wb_inst_o  = wb_q.inst;
    assign wb_we_o    = wb_q.wb_we;
    assign wb_waddr_o = wb_q.wb_waddr;
    assign wb_data_o  = wb_q.wb_data;

endmodule

//--- src/pipe_reg.sv
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d_i,
    output payload_t q_o
);

    // Whole payload clears, so valid and write enables drop with it
    always_ff @(posedge clk) begin
        if (rst_n) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

//--- src/ram_if.sv
interface ram_if #(
    parameter int AW = 8
) (
    input logic clk
);

    logic                            we;
    logic [mem_stage_pkg::BE_W-1:0]  be;
    logic [AW-1:0]                   addr;                 // Word index
    logic [mem_stage_pkg::XLEN-1:0]  wdata;
    logic [mem_stage_pkg::XLEN-1:0]  rdata;

    // The access unit clocks its checks from clk
    modport master (
        input  clk,
        output we,
        output be,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  we,
        input  be,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface
